//--- testbench/bp_stim.txt
# Codes: P pc expected, U pc taken, C pc history counter, F flush, D drain, R count
# pc is hex, other fields decimal, counter 0 strong not-taken up to 3 strong taken
P 00000100 0
P 000002a7 0
P deadbeef 0
U 00000040 1
D
C 00000040 0 2
P 00000040 0
U 00000040 1
U 00000040 1
U 00000040 1
U 00000040 1
U 00000040 1
U 00000040 1
D
C 00000040 15 3
P 00000040 1
U 00000040 0
D
C 00000040 15 2
P 00000040 0
U 00001005 1
U 00001005 0
U 00001005 1
U 00001005 0
U 00001005 1
U 00001005 0
U 00001005 1
U 00001005 0
D
C 00001005 10 3
P 00001005 1
U 00001005 1
D
P 00001005 0
P 00001239 0
U 00000039 1
U 00000039 1
U 00000039 1
U 00000039 1
U 00000039 1
U 00000039 1
D
P 00001239 1
P 00000039 1
F
U 00000040 1
D
C 00000040 0 2
C 00000040 15 1
C 00001005 10 1
P 00000040 0
P 00001005 0
P 00001239 0
R 24
D
F
P 00000040 0
P 00001005 0
P 00001239 0

//--- files.f
common/bp_pkg.sv
hw/bp_init_fsm.sv
hw/sweep_counter.sv
hw/update_queue.sv
local_pred/local_history_table.sv
local_pred/pattern_table.sv
hw/branch_predictor_top.sv
testbench/tb_branch_predictor.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the branch predictor testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f files.f --top-module tb_branch_predictor \
    -o tb_branch_predictor

# The log decides the result, tee keeps the pipeline status at zero
./obj_dir/tb_branch_predictor | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi

if ! grep -q "Testbench passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

echo "Simulation PASSED"

//--- testbench/tb_branch_predictor.sv
`timescale 1ns/10ps
`default_nettype none

module tb_branch_predictor;

    import bp_pkg::*;

    localparam int wait_limit = 1000;   // Longer than a full sweep in cycles

    logic                clk = 1'b0;
    logic                rst;
    logic                flush;
    logic                pred_req;
    logic [pc_width-1:0] pred_pc;
    logic                upd_valid;
    logic [pc_width-1:0] upd_pc;
    logic                upd_taken;
    logic                ready;
    logic                pred_valid;
    logic                prediction;
    logic                upd_credit;

    int     fd;
    int     credits;     // Credits the sender holds
    integer seed;

    branch_predictor_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .pred_req   (pred_req),
        .pred_pc    (pred_pc),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_taken  (upd_taken),
        .ready      (ready),
        .pred_valid (pred_valid),
        .prediction (prediction),
        .upd_credit (upd_credit)
    );

    always #50 clk = ~clk;

    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_prediction(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s expected %b, got %b", $time, name, expected, actual);
            fail_now("Output value mismatch");
        end
    endtask

    task automatic check_credits(string name, int expected, int actual);
        if (actual != expected) begin
            $display("[ERROR] %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            fail_now("Credit count mismatch");
        end
    endtask

    task automatic check_state(string name, counter_state_t expected, counter_state_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s expected %s, got %s", $time, name,
                     expected.name(), actual.name());
            fail_now("Pattern counter mismatch");
        end
    endtask

    // Advance to the next falling edge and collect a returned credit
    task automatic next_cycle();
        @(negedge clk);
        if (upd_credit) begin
            if (!ready) fail_now("A credit came back while the tables were being cleared");
            credits++;
            if (credits > upd_queue_depth) fail_now("More credits came back than were spent");
        end
    endtask

    task automatic wait_ready();
        int t;
        t = 0;
        while (!ready) begin
            if (t == wait_limit) fail_now("Timed out waiting for ready");
            next_cycle();
            t++;
        end
    endtask

    task automatic predict(logic [pc_width-1:0] pc, logic expected);
        int t;
        wait_ready();
        pred_req = 1'b1;
        pred_pc  = pc;
        next_cycle();
        pred_req = 1'b0;
        t = 0;
        while (!pred_valid) begin
            if (t == wait_limit) fail_now("Timed out waiting for pred_valid");
            next_cycle();
            t++;
        end
        check_prediction("prediction", expected, prediction);
    endtask

    task automatic send_update(logic [pc_width-1:0] pc, logic taken);
        int t;
        t = 0;
        while (credits == 0) begin
            if (t == wait_limit) fail_now("Timed out waiting for an update credit");
            next_cycle();
            t++;
        end
        upd_valid = 1'b1;
        upd_pc    = pc;
        upd_taken = taken;
        credits--;   // Spent as the update is raised
        next_cycle();
        upd_valid = 1'b0;
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (credits != upd_queue_depth) begin
            if (t == wait_limit) fail_now("Timed out waiting for all credits to return");
            next_cycle();
            t++;
        end
        next_cycle();   // Last drained entry lands at the edge after its credit
        // Every returned credit must match an entry that left the queue
        check_credits("queued updates", 0, dut0.upd_q0.count);
    endtask

    task automatic do_flush();
        wait_ready();
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        if (ready) fail_now("ready stayed high after a flush");
    endtask

    task automatic random_burst(int count);
        logic [pc_width-1:0] rnd_pc;
        int                  rnd;
        for (int i = 0; i < count; i++) begin
            rnd_pc = $random(seed);
            rnd    = $random(seed);
            send_update(rnd_pc, rnd[0]);
        end
    endtask

    // Peek at the counter selected by a PC and a history value
    task automatic check_counter(logic [pc_width-1:0] pc, int hist, int state);
        logic [pht_addr_bits-1:0] addr;
        addr = {pc[index_bits-1:0], hist[hist_bits-1:0]};
        check_state("pht counter", counter_state_t'(state[1:0]), dut0.pht0.pht[addr]);
    endtask

    task automatic check_fields(int got, int wanted);
        if (got != wanted) fail_now("Malformed line in the stim file");
    endtask

    task automatic run_commands();
        string               code;
        string               rest;
        logic [pc_width-1:0] pc;
        int                  a;
        int                  b;
        int                  n;
        bit                  done;
        done = 1'b0;
        while (!done) begin
            n = $fscanf(fd, "%s", code);
            if (n != 1) begin
                done = 1'b1;   // End of file
            end else if (code == "#") begin
                n = $fgets(rest, fd);
            end else if (code == "P") begin
                n = $fscanf(fd, "%h %d", pc, a);
                check_fields(n, 2);
                predict(pc, a[0]);
            end else if (code == "U") begin
                n = $fscanf(fd, "%h %d", pc, a);
                check_fields(n, 2);
                send_update(pc, a[0]);
            end else if (code == "C") begin
                n = $fscanf(fd, "%h %d %d", pc, a, b);
                check_fields(n, 3);
                check_counter(pc, a, b);
            end else if (code == "R") begin
                n = $fscanf(fd, "%d", a);
                check_fields(n, 1);
                random_burst(a);
            end else if (code == "F") begin
                do_flush();
            end else if (code == "D") begin
                drain();
            end else begin
                fail_now({"Unknown command ", code, " in the stim file"});
            end
        end
    endtask

    initial begin
        seed      = 88101;
        rst       = 1'b1;
        flush     = 1'b0;
        pred_req  = 1'b0;
        pred_pc   = '0;
        upd_valid = 1'b0;
        upd_pc    = '0;
        upd_taken = 1'b0;
        credits   = upd_queue_depth;

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_prediction("ready", 1'b0, ready);
        check_prediction("pred_valid", 1'b0, pred_valid);
        check_prediction("prediction", 1'b0, prediction);
        check_prediction("upd_credit", 1'b0, upd_credit);
        rst = 1'b0;

        fd = $fopen("testbench/bp_stim.txt", "r");
        if (fd == 0) fail_now("Could not open testbench/bp_stim.txt");
        wait_ready();
        run_commands();
        $fclose(fd);

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/branch_predictor_top.sv
`timescale 1ns/10ps
`default_nettype none

module branch_predictor_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  logic                        pred_req,
    input  logic [bp_pkg::pc_width-1:0] pred_pc,
    input  logic                        upd_valid,
    input  logic [bp_pkg::pc_width-1:0] upd_pc,
    input  logic                        upd_taken,
    output logic                        ready,
    output logic                        pred_valid,
    output logic                        prediction,
    output logic                        upd_credit
);

    import bp_pkg::*;

    // Sweep control
    logic                     sweep_en;
    logic                     sweep_last;
    logic [pht_addr_bits-1:0] sweep_idx;

    // Drained update
    logic                     drain_en;
    logic                     apply_valid;
    logic [index_bits-1:0]    apply_idx;
    logic                     apply_taken;
    logic [hist_bits-1:0]     apply_hist;

    // Prediction lookup
    logic                     pred_req_gated;
    logic [index_bits-1:0]    pred_idx;
    logic [hist_bits-1:0]     pred_hist;

    assign pred_idx       = pred_pc[index_bits-1:0];
    assign pred_req_gated = pred_req && ready;   // Requests during a sweep are dropped
    assign drain_en       = ready;               // Queue holds updates until tables are clear

    bp_init_fsm init_fsm0 (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .sweep_last (sweep_last),
        .sweep_en   (sweep_en),
        .ready      (ready)
    );

    sweep_counter sweep_cnt0 (
        .clk        (clk),
        .rst        (rst),
        .sweep_en   (sweep_en),
        .sweep_idx  (sweep_idx),
        .sweep_last (sweep_last)
    );

    update_queue upd_q0 (
        .clk         (clk),
        .rst         (rst),
        .upd_valid   (upd_valid),
        .upd_pc      (upd_pc),
        .upd_taken   (upd_taken),
        .drain_en    (drain_en),
        .apply_valid (apply_valid),
        .apply_idx   (apply_idx),
        .apply_taken (apply_taken),
        .upd_credit  (upd_credit)
    );

    local_history_table bht0 (
        .clk         (clk),
        .rst         (rst),
        .sweep_en    (sweep_en),
        .sweep_idx   (sweep_idx[index_bits-1:0]),   // BHT is smaller, low bits cover it
        .apply_valid (apply_valid),
        .apply_idx   (apply_idx),
        .apply_taken (apply_taken),
        .pred_idx    (pred_idx),
        .apply_hist  (apply_hist),
        .pred_hist   (pred_hist)
    );

    pattern_table pht0 (
        .clk         (clk),
        .rst         (rst),
        .sweep_en    (sweep_en),
        .sweep_idx   (sweep_idx),
        .apply_valid (apply_valid),
        .apply_idx   (apply_idx),
        .apply_hist  (apply_hist),
        .apply_taken (apply_taken),
        .pred_req    (pred_req_gated),
        .pred_idx    (pred_idx),
        .pred_hist   (pred_hist),
        .pred_valid  (pred_valid),
        .prediction  (prediction)
    );

endmodule

`default_nettype wire

//--- local_pred/pattern_table.sv
`timescale 1ns/10ps
`default_nettype none

module pattern_table (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             sweep_en,
    input  logic [bp_pkg::pht_addr_bits-1:0] sweep_idx,
    input  logic                             apply_valid,
    input  logic [bp_pkg::index_bits-1:0]    apply_idx,
    input  logic [bp_pkg::hist_bits-1:0]     apply_hist,
    input  logic                             apply_taken,
    input  logic                             pred_req,
    input  logic [bp_pkg::index_bits-1:0]    pred_idx,
    input  logic [bp_pkg::hist_bits-1:0]     pred_hist,
    output logic                             pred_valid,
    output logic                             prediction
);

    import bp_pkg::*;

    counter_state_t         pht [pht_entries];

    logic [pht_addr_bits-1:0] apply_addr;
    logic [pht_addr_bits-1:0] pred_addr;
    counter_state_t           apply_cur;
    counter_state_t           apply_next;
    counter_state_t           pred_cur;

    assign apply_addr = {apply_idx, apply_hist};
    assign pred_addr  = {pred_idx, pred_hist};
    assign apply_cur  = pht[apply_addr];
    assign pred_cur   = pht[pred_addr];

    // One step toward the outcome, held at either end
    always_comb begin
        apply_next = apply_cur;
        if (apply_taken) begin
            if (apply_cur != strong_taken) begin
                apply_next = counter_state_t'(apply_cur + 2'd1);
            end
        end else if (apply_cur != strong_not_taken) begin
            apply_next = counter_state_t'(apply_cur - 2'd1);
        end
    end

    always_ff @(posedge clk) begin
        if (sweep_en) begin
            pht[sweep_idx] <= weak_not_taken;
        end else if (apply_valid) begin
            pht[apply_addr] <= apply_next;
        end
    end

    // Prediction samples the table before this edge's write lands
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pred_valid <= 1'b0;
            prediction <= 1'b0;
        end else begin
            pred_valid <= pred_req;
            prediction <= pred_req && ((pred_cur == weak_taken) || (pred_cur == strong_taken));
        end
    end

endmodule

`default_nettype wire

//--- local_pred/local_history_table.sv
`timescale 1ns/10ps
`default_nettype none

module local_history_table (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          sweep_en,
    input  logic [bp_pkg::index_bits-1:0] sweep_idx,
    input  logic                          apply_valid,
    input  logic [bp_pkg::index_bits-1:0] apply_idx,
    input  logic                          apply_taken,
    input  logic [bp_pkg::index_bits-1:0] pred_idx,
    output logic [bp_pkg::hist_bits-1:0]  apply_hist,
    output logic [bp_pkg::hist_bits-1:0]  pred_hist
);

    import bp_pkg::*;

    // One outcome shift register per branch index, newest outcome in bit 0
    logic [hist_bits-1:0] bht [bht_entries];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bht_entries; i++) begin
                bht[i] <= '0;
            end
        end else if (sweep_en) begin
            bht[sweep_idx] <= '0;   // Sweep revisits each entry many times
        end else if (apply_valid) begin
            bht[apply_idx] <= {bht[apply_idx][hist_bits-2:0], apply_taken};
        end
    end

    // Update path sees the history before this outcome is shifted in
    assign apply_hist = bht[apply_idx];
    assign pred_hist  = bht[pred_idx];

endmodule

`default_nettype wire

//--- hw/update_queue.sv
`timescale 1ns/10ps
`default_nettype none

module update_queue (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          upd_valid,
    input  logic [bp_pkg::pc_width-1:0]   upd_pc,
    input  logic                          upd_taken,
    input  logic                          drain_en,
    output logic                          apply_valid,
    output logic [bp_pkg::index_bits-1:0] apply_idx,
    output logic                          apply_taken,
    output logic                          upd_credit
);

    import bp_pkg::*;

    // Payload storage, only the table index of the PC is kept
    logic [index_bits-1:0]     idx_mem [upd_queue_depth];
    logic                      taken_mem [upd_queue_depth];

    logic [queue_ptr_bits-1:0] wr_ptr;
    logic [queue_ptr_bits-1:0] rd_ptr;
    logic [queue_cnt_bits-1:0] count;

    logic                      push;
    logic                      pop;

    // The sender only raises upd_valid while it holds a credit
    assign push = upd_valid;
    assign pop  = drain_en && (count != '0);

    // Head entry is presented for the single cycle it drains
    assign apply_valid = pop;
    assign apply_idx   = idx_mem[rd_ptr];
    assign apply_taken = taken_mem[rd_ptr];
    assign upd_credit  = pop;   // Slot freed, credit goes back to the sender

    always_ff @(posedge clk) begin
        if (push) begin
            idx_mem[wr_ptr]   <= upd_pc[index_bits-1:0];
            taken_mem[wr_ptr] <= upd_taken;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // Depth is a power of two, pointers wrap
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Idle, or one in and one out
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/sweep_counter.sv
`timescale 1ns/10ps
`default_nettype none

module sweep_counter (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             sweep_en,
    output logic [bp_pkg::pht_addr_bits-1:0] sweep_idx,
    output logic                             sweep_last
);

    import bp_pkg::*;

    // Final address of the pattern table
    assign sweep_last = (sweep_idx == pht_addr_bits'(pht_entries - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sweep_idx <= '0;
        end else if (sweep_en) begin
            if (sweep_last) begin
                sweep_idx <= '0;   // Next sweep starts from the bottom again
            end else begin
                sweep_idx <= sweep_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/bp_init_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module bp_init_fsm (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic sweep_last,
    output logic sweep_en,
    output logic ready
);

    import bp_pkg::*;

    init_state_t state;
    init_state_t state_next;

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            init_sweep: begin
                if (sweep_last) begin
                    state_next = init_ready;   // Last table entry written this cycle
                end
            end
            init_ready: begin
                if (flush) begin
                    state_next = init_sweep;
                end
            end
            default: state_next = init_sweep;
        endcase
    end

    // A reset always starts a fresh sweep
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= init_sweep;
            ready <= 1'b0;
        end else begin
            state <= state_next;
            ready <= (state_next == init_ready);   // Rises with the state, never mid-sweep
        end
    end

    assign sweep_en = (state == init_sweep);

endmodule

`default_nettype wire

//--- common/bp_pkg.sv
`default_nettype none

package bp_pkg;

    // Branch address and table geometry
    localparam int pc_width      = 32;
    localparam int index_bits    = 4;                        // Low PC bits into the BHT
    localparam int hist_bits     = 4;                        // Outcomes kept per branch
    localparam int bht_entries   = 2 ** index_bits;
    localparam int pht_addr_bits = index_bits + hist_bits;   // {PC index, history}
    localparam int pht_entries   = 2 ** pht_addr_bits;       // Also the sweep length

    // Update queue, one credit per slot
    localparam int upd_queue_depth = 4;
    localparam int queue_ptr_bits  = $clog2(upd_queue_depth);
    localparam int queue_cnt_bits  = queue_ptr_bits + 1;     // Holds 0 to depth

    // Two-bit saturating counter, upper half predicts taken
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } counter_state_t;

    // Table sequencer states
    typedef enum logic {
        init_sweep = 1'b0,   // Clearing one table entry per cycle
        init_ready = 1'b1    // Tables valid, predictions and updates allowed
    } init_state_t;

endpackage

`default_nettype wire
